/* rtl/mmu_settings.svh */
// Width, depth and region constants of the data translation path.
// Included by the package and by every RTL file that sizes logic from them.

`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Sv39 virtual and physical address widths
`define MMU_VADDR_W 39
`define MMU_PADDR_W 40
`define MMU_PAGE_OFFSET_W 12

`define MMU_VTAG_W 27
`define MMU_PTAG_W 28

// Any power of two works here
`define MMU_TLB_ELS 8

// I/O domain field, top bits of the physical tag
`define MMU_DID_W 3

// Tags below this point to uncached I/O space, under 2 GB
`define MMU_UNCACHED_PTAG_LIMIT 28'h0080000

`endif

/* rtl/mmu_pkg.sv */
// Types shared by the data TLB, the access checker and the top level.
// Modules import it in their bodies and name its types with mmu_pkg:: on their ports.

`include "mmu_settings.svh"

package mmu_pkg;

  typedef enum logic [1:0] {
    e_priv_user       = 2'd0,
    e_priv_supervisor = 2'd1,
    e_priv_machine    = 2'd3
  } priv_mode_e;

  // Load or store command from the execute stage
  typedef struct packed {
    logic [`MMU_VADDR_W-1:0] vaddr;
    logic                    is_store;
  } mmu_cmd_s;

  // Leaf PTE bits kept per TLB entry
  typedef struct packed {
    logic [`MMU_PTAG_W-1:0] ptag;
    logic                   u;
    logic                   w;
    logic                   d;
  } tlb_entry_s;

  typedef struct packed {
    logic [`MMU_VTAG_W-1:0] vtag;
    tlb_entry_s             entry;
  } tlb_fill_s;

  // Registered lookup result, stage 1 to stage 2
  typedef struct packed {
    logic                          v;
    logic                          is_store;
    logic                          hit;
    tlb_entry_s                    entry;
    logic [`MMU_PAGE_OFFSET_W-1:0] page_offset;
  } tlb_lookup_s;

  typedef struct packed {
    logic                    miss;
    logic                    load_page_fault;
    logic                    store_page_fault;
    logic                    load_access_fault;
    logic                    store_access_fault;
    logic [`MMU_PADDR_W-1:0] paddr;
  } mem_resp_s;

endpackage

/* rtl/dtlb.sv */
// Fully associative data TLB.
// Registers the command, compares its tag against all entries and registers
// the result one cycle later. Filled from outside, flushed by sfence.

`timescale 1ns/1ps

`include "mmu_settings.svh"

module dtlb (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                translation_en_i,
  input  logic                cmd_v_i,
  input  mmu_pkg::mmu_cmd_s   cmd_i,
  input  logic                poison_i,
  input  logic                fill_v_i,
  input  mmu_pkg::tlb_fill_s  fill_i,
  input  logic                flush_i,
  output mmu_pkg::tlb_lookup_s lookup_o
);

  import mmu_pkg::*;

  localparam int ELS   = `MMU_TLB_ELS;
  localparam int PTR_W = (ELS > 1) ? $clog2(ELS) : 1;

  logic                   valid_q [ELS];
  logic [`MMU_VTAG_W-1:0] vtag_q  [ELS];
  tlb_entry_s             entry_q [ELS];
  logic [PTR_W-1:0]       fill_ptr_q;

  logic                   cmd_v_q;
  mmu_cmd_s               cmd_q;
  logic [`MMU_VTAG_W-1:0] cmd_vtag;

  logic [ELS-1:0]         hit_vec;
  logic [ELS-1:0]         fill_match_vec;
  logic [PTR_W-1:0]       fill_match_idx;
  logic [PTR_W-1:0]       fill_idx;
  tlb_entry_s             hit_entry;
  tlb_entry_s             pass_entry;
  tlb_lookup_s            lookup_q;

  // Stage 0 command capture
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_q <= 1'b0;
    end else begin
      cmd_v_q <= cmd_v_i;
    end
    cmd_q <= cmd_i;
  end

  assign cmd_vtag = cmd_q.vaddr[`MMU_VADDR_W-1:`MMU_PAGE_OFFSET_W];

  // Parallel compare, entries are unique so OR-ing the hits is safe
  always_comb begin
    hit_entry = '0;
    for (int i = 0; i < ELS; i++) begin
      hit_vec[i] = valid_q[i] & (vtag_q[i] == cmd_vtag);
      if (hit_vec[i]) begin
        hit_entry = tlb_entry_s'(hit_entry | entry_q[i]);
      end
    end
  end

  // Identity mapping when translation is off
  assign pass_entry = '{ptag: `MMU_PTAG_W'(cmd_vtag), u: 1'b0, w: 1'b1, d: 1'b1};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lookup_q.v <= 1'b0;
    end else begin
      lookup_q.v <= cmd_v_q & ~poison_i;
    end
    lookup_q.is_store    <= cmd_q.is_store;
    lookup_q.hit         <= translation_en_i ? |hit_vec : 1'b1;
    lookup_q.entry       <= translation_en_i ? hit_entry : pass_entry;
    lookup_q.page_offset <= cmd_q.vaddr[`MMU_PAGE_OFFSET_W-1:0];
  end

  assign lookup_o = lookup_q;

  // A refill of a present tag reuses its slot
  always_comb begin
    fill_match_idx = '0;
    for (int i = 0; i < ELS; i++) begin
      fill_match_vec[i] = valid_q[i] & (vtag_q[i] == fill_i.vtag);
      if (fill_match_vec[i]) begin
        fill_match_idx = PTR_W'(i);
      end
    end
  end

  assign fill_idx = (|fill_match_vec) ? fill_match_idx : fill_ptr_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      fill_ptr_q <= '0;
      for (int i = 0; i < ELS; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (fill_v_i) begin
      valid_q[fill_idx] <= 1'b1;
      if (!(|fill_match_vec)) begin
        fill_ptr_q <= fill_ptr_q + PTR_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      vtag_q[fill_idx]  <= fill_i.vtag;
      entry_q[fill_idx] <= fill_i.entry;
    end
  end

  a_fill_flush_excl: assert property (
    @(posedge clk_i) disable iff (reset_i) !(fill_v_i && flush_i)
  ) else $error("dtlb fill and sfence in the same cycle");

  // Replacement must never leave two live copies of one tag
  a_unique_hit: assert property (
    @(posedge clk_i) disable iff (reset_i) cmd_v_q |-> $onehot0(hit_vec)
  ) else $error("dtlb multiple entries match one vtag");

endmodule

/* rtl/access_check.sv */
// Stage 2 of the translation path.
// Applies privilege, write and physical attribute checks to the TLB result
// and registers the memory response.

`timescale 1ns/1ps

`include "mmu_settings.svh"

module access_check (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  mmu_pkg::tlb_lookup_s lookup_i,
  input  logic                 translation_en_i,
  input  mmu_pkg::priv_mode_e  priv_mode_i,
  input  logic                 mstatus_sum_i,
  input  logic                 uncached_mode_i,
  output logic                 resp_v_o,
  output mmu_pkg::mem_resp_s   resp_o
);

  import mmu_pkg::*;

  logic                   miss;
  logic                   priv_fault;
  logic                   write_fault;
  logic                   did_fault;
  logic                   mode_fault;
  logic                   attr_fault;
  logic                   page_check;
  logic [`MMU_PTAG_W-1:0] ptag;
  mem_resp_s              resp_d;
  mem_resp_s              resp_q;
  logic                   resp_v_q;

  assign ptag = lookup_i.entry.ptag;
  assign miss = translation_en_i & ~lookup_i.hit;

  // Page checks only when a real PTE backs the access
  assign page_check = translation_en_i & ~miss;

  assign priv_fault =
      ((priv_mode_i == e_priv_supervisor) & ~mstatus_sum_i & lookup_i.entry.u)
    | ((priv_mode_i == e_priv_user) & ~lookup_i.entry.u);

  assign write_fault = ~lookup_i.entry.w | ~lookup_i.entry.d;

  // Only domain 0 is reachable from this core
  assign did_fault  = ptag[`MMU_PTAG_W-1 -: `MMU_DID_W] != '0;
  assign mode_fault = uncached_mode_i & (ptag >= `MMU_UNCACHED_PTAG_LIMIT);
  assign attr_fault = ~miss & (did_fault | mode_fault);

  always_comb begin
    resp_d.miss               = miss;
    resp_d.load_page_fault    = page_check & ~lookup_i.is_store & priv_fault;
    resp_d.store_page_fault   = page_check & lookup_i.is_store & (priv_fault | write_fault);
    resp_d.load_access_fault  = attr_fault & ~lookup_i.is_store;
    resp_d.store_access_fault = attr_fault & lookup_i.is_store;
    resp_d.paddr              = miss ? '0 : {ptag, lookup_i.page_offset};
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_q <= 1'b0;
    end else begin
      resp_v_q <= lookup_i.v;
    end
    resp_q <= resp_d;
  end

  assign resp_v_o = resp_v_q;
  assign resp_o   = resp_q;

  // Miss reaches the core as a refill request, never as an exception
  a_miss_no_fault: assert property (
    @(posedge clk_i) disable iff (reset_i)
      resp_v_o |-> !(resp_o.miss && (resp_o.load_page_fault || resp_o.store_page_fault
                     || resp_o.load_access_fault || resp_o.store_access_fault))
  ) else $error("access_check miss reported with a fault");

  a_dir_exclusive: assert property (
    @(posedge clk_i) disable iff (reset_i)
      resp_v_o |-> !((resp_o.load_page_fault || resp_o.load_access_fault)
                     && (resp_o.store_page_fault || resp_o.store_access_fault))
  ) else $error("access_check load and store faults both set");

endmodule

/* rtl/mem_xlate_top.sv */
// Top of the data translation path.
// A command goes through the TLB stage and the check stage and returns one
// response two cycles later unless poisoned in flight.

`timescale 1ns/1ps

module mem_xlate_top (
  input  logic                clk_i,
  input  logic                reset_i,

  input  logic                mmu_cmd_v_i,
  input  mmu_pkg::mmu_cmd_s   mmu_cmd_i,

  input  logic                tlb_fill_v_i,
  input  mmu_pkg::tlb_fill_s  tlb_fill_i,
  input  logic                sfence_i,
  input  logic                poison_i,

  // Configuration levels
  input  logic                translation_en_i,
  input  mmu_pkg::priv_mode_e priv_mode_i,
  input  logic                mstatus_sum_i,
  input  logic                uncached_mode_i,

  output logic                mem_resp_v_o,
  output mmu_pkg::mem_resp_s  mem_resp_o
);

  import mmu_pkg::*;

  tlb_lookup_s lookup;

  // Poison lands in the TLB stage so the checker only sees live commands
  dtlb u_dtlb (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .translation_en_i (translation_en_i),
    .cmd_v_i          (mmu_cmd_v_i),
    .cmd_i            (mmu_cmd_i),
    .poison_i         (poison_i),
    .fill_v_i         (tlb_fill_v_i),
    .fill_i           (tlb_fill_i),
    .flush_i          (sfence_i),
    .lookup_o         (lookup)
  );

  access_check u_access_check (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .lookup_i         (lookup),
    .translation_en_i (translation_en_i),
    .priv_mode_i      (priv_mode_i),
    .mstatus_sum_i    (mstatus_sum_i),
    .uncached_mode_i  (uncached_mode_i),
    .resp_v_o         (mem_resp_v_o),
    .resp_o           (mem_resp_o)
  );

endmodule

/* verification/tb_mem_xlate.sv */
// Testbench for the data translation path.
// Drives commands, fills, sfence and poison on the falling edge. A model
// process keeps its own TLB and pipeline, and a compare process checks every
// response in order against the expected queue.

`timescale 1ns/1ps

`include "mmu_settings.svh"

module tb_mem_xlate;

  import mmu_pkg::*;

  localparam int ELS         = `MMU_TLB_ELS;
  localparam int DRAIN_LIMIT = 100;

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       mmu_cmd_v_i;
  mmu_cmd_s   mmu_cmd_i;
  logic       tlb_fill_v_i;
  tlb_fill_s  tlb_fill_i;
  logic       sfence_i;
  logic       poison_i;
  logic       translation_en_i;
  priv_mode_e priv_mode_i;
  logic       mstatus_sum_i;
  logic       uncached_mode_i;
  logic       mem_resp_v_o;
  mem_resp_s  mem_resp_o;

  // Model TLB and pipeline stages
  logic                   m_valid [ELS];
  logic [`MMU_VTAG_W-1:0] m_vtag  [ELS];
  tlb_entry_s             m_entry [ELS];
  int                     m_ptr;
  logic                   s0_v;
  mmu_cmd_s               s0_cmd;
  logic                   s1_v;
  tlb_lookup_s            s1;
  logic                   resp_due;
  mem_resp_s              exp_q [$];
  mem_resp_s              exp_resp;
  int                     live_count = 0;
  int                     resp_count = 0;
  int                     miss_seen  = 0;

  integer      seed;
  logic [31:0] rnd_a;
  logic [31:0] rnd_b;
  logic [31:0] rnd_c;
  priv_mode_e  cfg_priv;
  int          resp_before;
  int          miss_before;

  mem_xlate_top u_mem_xlate_top (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .mmu_cmd_v_i      (mmu_cmd_v_i),
    .mmu_cmd_i        (mmu_cmd_i),
    .tlb_fill_v_i     (tlb_fill_v_i),
    .tlb_fill_i       (tlb_fill_i),
    .sfence_i         (sfence_i),
    .poison_i         (poison_i),
    .translation_en_i (translation_en_i),
    .priv_mode_i      (priv_mode_i),
    .mstatus_sum_i    (mstatus_sum_i),
    .uncached_mode_i  (uncached_mode_i),
    .mem_resp_v_o     (mem_resp_v_o),
    .mem_resp_o       (mem_resp_o)
  );

  always #5 clk_i = ~clk_i;

  // Expected response from a looked-up entry and the configuration levels
  function automatic mem_resp_s ref_resp(input tlb_lookup_s lk, input logic ten,
                                         input priv_mode_e priv, input logic sum,
                                         input logic unc);
    mem_resp_s             r;
    logic                  pf;
    logic                  af;
    logic [`MMU_DID_W-1:0] dom;
    r = '0;
    r.miss = ten && !lk.hit;
    if (!r.miss) begin
      r.paddr = {lk.entry.ptag, lk.page_offset};
      pf  = ten && (((priv == e_priv_supervisor) && !sum && lk.entry.u)
                    || ((priv == e_priv_user) && !lk.entry.u));
      dom = lk.entry.ptag[`MMU_PTAG_W-1 -: `MMU_DID_W];
      af  = (dom != '0) || (unc && (lk.entry.ptag >= `MMU_UNCACHED_PTAG_LIMIT));
      r.load_page_fault    = !lk.is_store && pf;
      r.store_page_fault   = lk.is_store && (pf || (ten && (!lk.entry.w || !lk.entry.d)));
      r.load_access_fault  = !lk.is_store && af;
      r.store_access_fault = lk.is_store && af;
    end
    return r;
  endfunction

  function automatic tlb_lookup_s lookup_now(input mmu_cmd_s c, input logic ten);
    tlb_lookup_s            lk;
    logic [`MMU_VTAG_W-1:0] vt;
    lk = '0;
    vt = c.vaddr[`MMU_VADDR_W-1:`MMU_PAGE_OFFSET_W];
    lk.is_store    = c.is_store;
    lk.page_offset = c.vaddr[`MMU_PAGE_OFFSET_W-1:0];
    if (!ten) begin
      // Identity mapping is writable and dirty
      lk.hit        = 1'b1;
      lk.entry.ptag = `MMU_PTAG_W'(vt);
      lk.entry.w    = 1'b1;
      lk.entry.d    = 1'b1;
    end else begin
      for (int i = 0; i < ELS; i++) begin
        if (m_valid[i] && (m_vtag[i] == vt)) begin
          lk.hit   = 1'b1;
          lk.entry = m_entry[i];
        end
      end
    end
    return lk;
  endfunction

  task automatic apply_fill(input tlb_fill_s f);
    int idx;
    idx = -1;
    for (int i = 0; i < ELS; i++) begin
      if (m_valid[i] && (m_vtag[i] == f.vtag)) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      idx   = m_ptr;
      m_ptr = (m_ptr + 1) % ELS;
    end
    m_valid[idx] = 1'b1;
    m_vtag[idx]  = f.vtag;
    m_entry[idx] = f.entry;
  endtask

  task automatic flush_model();
    m_ptr = 0;
    for (int i = 0; i < ELS; i++) begin
      m_valid[i] = 1'b0;
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      s0_v = 1'b0;
      s1_v = 1'b0;
      resp_due <= 1'b0;
      flush_model();
    end else begin
      // Stage 2 sees the configuration at the response edge
      resp_due <= s1_v;
      if (s1_v) begin
        exp_q.push_back(ref_resp(s1, translation_en_i, priv_mode_i,
                                 mstatus_sum_i, uncached_mode_i));
        live_count++;
      end
      s1_v   = s0_v && !poison_i;
      s1     = lookup_now(s0_cmd, translation_en_i);
      s0_v   = mmu_cmd_v_i;
      s0_cmd = mmu_cmd_i;
      if (sfence_i) begin
        flush_model();
      end else if (tlb_fill_v_i) begin
        apply_fill(tlb_fill_i);
      end
    end
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      // Valid exactly two cycles after each live command
      assert (mem_resp_v_o === resp_due) else begin
        $display("** Error at %0t ns: response valid %b, expected %b",
                 $time, mem_resp_v_o, resp_due);
        abort_run();
      end
    end
    if (!reset_i && (mem_resp_v_o === 1'b1)) begin
      if (exp_q.size() == 0) begin
        $display("A response arrived while no command was outstanding");
        abort_run();
      end else begin
        exp_resp = exp_q.pop_front();
        resp_count++;
        if (mem_resp_o.miss) begin
          miss_seen++;
        end
        assert (mem_resp_o == exp_resp) else begin
          $display("** Error at %0t ns: response %h, expected %h",
                   $time, mem_resp_o, exp_resp);
          abort_run();
        end
      end
    end
  end

  task automatic check_count(input int got, input int want, input string what);
    assert (got == want) else begin
      $display("** Error at %0t ns: %s count is %0d, expected %0d", $time, what, got, want);
      abort_run();
    end
  endtask

  function automatic logic [`MMU_VTAG_W-1:0] pool_vtag(input int idx);
    return `MMU_VTAG_W'(27'h0040000 + idx);
  endfunction

  function automatic logic [`MMU_PTAG_W-1:0] pick_ptag(input logic [31:0] r);
    case (r[1:0])
      2'd0:    return {9'h000, r[20:2]};
      2'd1:    return {3'b000, 6'b000001, r[20:2]};
      2'd2:    return {3'b000, r[26:2]};
      default: return r[29:2];
    endcase
  endfunction

  task automatic clear_strobes();
    mmu_cmd_v_i  = 1'b0;
    tlb_fill_v_i = 1'b0;
    sfence_i     = 1'b0;
    poison_i     = 1'b0;
  endtask

  task automatic issue_cmd(input logic [`MMU_VTAG_W-1:0] vt,
                           input logic [`MMU_PAGE_OFFSET_W-1:0] off,
                           input logic st, input logic psn);
    @(negedge clk_i);
    clear_strobes();
    mmu_cmd_v_i = 1'b1;
    mmu_cmd_i   = '{vaddr: {vt, off}, is_store: st};
    poison_i    = psn;
  endtask

  task automatic issue_poison();
    @(negedge clk_i);
    clear_strobes();
    poison_i = 1'b1;
  endtask

  task automatic issue_fill(input logic [`MMU_VTAG_W-1:0] vt, input logic [`MMU_PTAG_W-1:0] pt,
                            input logic u, input logic w, input logic d);
    @(negedge clk_i);
    clear_strobes();
    tlb_fill_v_i = 1'b1;
    tlb_fill_i   = '{vtag: vt, entry: '{ptag: pt, u: u, w: w, d: d}};
  endtask

  task automatic issue_sfence();
    @(negedge clk_i);
    clear_strobes();
    sfence_i = 1'b1;
  endtask

  task automatic set_config(input logic ten, input priv_mode_e priv, input logic sum,
                            input logic unc);
    @(negedge clk_i);
    clear_strobes();
    translation_en_i = ten;
    priv_mode_i      = priv;
    mstatus_sum_i    = sum;
    uncached_mode_i  = unc;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      clear_strobes();
      cycles++;
    end while ((s0_v || s1_v || (exp_q.size() != 0)) && (cycles < DRAIN_LIMIT));
    if (s0_v || s1_v || (exp_q.size() != 0)) begin
      $display("Pipeline did not drain within %0d cycles, responses are missing", DRAIN_LIMIT);
      abort_run();
    end
  endtask

  initial begin
    seed             = 32'hd648baf1;
    reset_i          = 1'b1;
    mmu_cmd_v_i      = 1'b0;
    mmu_cmd_i        = '0;
    tlb_fill_v_i     = 1'b0;
    tlb_fill_i       = '0;
    sfence_i         = 1'b0;
    poison_i         = 1'b0;
    translation_en_i = 1'b0;
    priv_mode_i      = e_priv_user;
    mstatus_sum_i    = 1'b0;
    uncached_mode_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Bare mode back to back in user mode
    resp_before = resp_count;
    for (int i = 0; i < 8; i++) begin
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      issue_cmd({4'h0, rnd_a[22:0]}, rnd_b[11:0], rnd_b[12], 1'b0);
    end
    wait_drain();
    check_count(resp_count - resp_before, 8, "bare mode response");

    // Hits, misses, replacement and sfence
    set_config(1'b1, e_priv_supervisor, 1'b1, 1'b0);
    issue_sfence();
    for (int i = 0; i < 4; i++) begin
      issue_fill(pool_vtag(i), 28'h0100000 + 28'(i), 1'b0, 1'b1, 1'b1);
    end
    miss_before = miss_seen;
    for (int i = 0; i < 4; i++) begin
      issue_cmd(pool_vtag(i), 12'h0a4, 1'b0, 1'b0);
    end
    issue_cmd(pool_vtag(10), 12'h010, 1'b0, 1'b0);
    issue_cmd(pool_vtag(11), 12'h020, 1'b1, 1'b0);
    wait_drain();
    check_count(miss_seen - miss_before, 2, "unfilled tag miss");
    for (int i = 4; i < ELS + 2; i++) begin
      issue_fill(pool_vtag(i), 28'h0100000 + 28'(i), 1'b0, 1'b1, 1'b1);
    end
    issue_fill(pool_vtag(5), 28'h0200005, 1'b0, 1'b1, 1'b1);
    miss_before = miss_seen;
    for (int i = 0; i < ELS + 2; i++) begin
      issue_cmd(pool_vtag(i), 12'h3f8, i[0], 1'b0);
    end
    wait_drain();
    check_count(miss_seen - miss_before, 2, "evicted entry miss");
    issue_sfence();
    miss_before = miss_seen;
    for (int i = 0; i < ELS + 2; i++) begin
      issue_cmd(pool_vtag(i), 12'h000, 1'b0, 1'b0);
    end
    wait_drain();
    check_count(miss_seen - miss_before, ELS + 2, "post-sfence miss");

    // Privilege, SUM and write permission
    issue_fill(pool_vtag(0), 28'h0110000, 1'b1, 1'b1, 1'b1);
    issue_fill(pool_vtag(1), 28'h0110001, 1'b0, 1'b1, 1'b1);
    issue_fill(pool_vtag(2), 28'h0110002, 1'b0, 1'b0, 1'b1);
    issue_fill(pool_vtag(3), 28'h0110003, 1'b0, 1'b1, 1'b0);
    issue_fill(pool_vtag(4), 28'h0110004, 1'b1, 1'b0, 1'b1);
    for (int k = 0; k < 5; k++) begin
      if (k < 2) begin
        cfg_priv = e_priv_user;
      end else if (k < 4) begin
        cfg_priv = e_priv_supervisor;
      end else begin
        cfg_priv = e_priv_machine;
      end
      set_config(1'b1, cfg_priv, k[0], 1'b0);
      for (int p = 0; p < 5; p++) begin
        issue_cmd(pool_vtag(p), 12'h040, 1'b0, 1'b0);
        issue_cmd(pool_vtag(p), 12'h048, 1'b1, 1'b0);
      end
      wait_drain();
    end

    // Domain and uncached-mode access faults
    issue_sfence();
    issue_fill(pool_vtag(0), 28'h4000010, 1'b0, 1'b1, 1'b1);
    issue_fill(pool_vtag(1), 28'h0100000, 1'b0, 1'b1, 1'b1);
    issue_fill(pool_vtag(2), 28'h0000100, 1'b0, 1'b1, 1'b1);
    for (int u = 0; u < 2; u++) begin
      set_config(1'b1, e_priv_machine, 1'b0, u[0]);
      for (int p = 0; p < 3; p++) begin
        issue_cmd(pool_vtag(p), 12'h100, 1'b0, 1'b0);
        issue_cmd(pool_vtag(p), 12'h104, 1'b1, 1'b0);
      end
      wait_drain();
    end
    set_config(1'b0, e_priv_machine, 1'b0, 1'b1);
    issue_cmd(27'h0000123, 12'h010, 1'b0, 1'b0);
    issue_cmd(27'h0000124, 12'h020, 1'b1, 1'b0);
    wait_drain();

    // Poison one cycle after B and after E
    resp_before = resp_count;
    issue_cmd(27'h0000a01, 12'h001, 1'b0, 1'b0);
    issue_cmd(27'h0000a02, 12'h002, 1'b1, 1'b0);
    issue_cmd(27'h0000a03, 12'h003, 1'b0, 1'b1);
    issue_cmd(27'h0000a04, 12'h004, 1'b1, 1'b0);
    issue_cmd(27'h0000a05, 12'h005, 1'b0, 1'b0);
    issue_poison();
    wait_drain();
    check_count(resp_count - resp_before, 3, "response after poison");

    // Random mix
    set_config(1'b1, e_priv_supervisor, 1'b0, 1'b0);
    for (int c = 0; c < 400; c++) begin
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      rnd_c = $random(seed);
      @(negedge clk_i);
      clear_strobes();
      mmu_cmd_v_i = rnd_a[0];
      mmu_cmd_i   = '{vaddr: {pool_vtag(int'(rnd_a[5:2])), rnd_b[11:0]}, is_store: rnd_a[6]};
      if (rnd_a[10:8] == 3'd0) begin
        tlb_fill_v_i = 1'b1;
        tlb_fill_i   = '{vtag: pool_vtag(int'(rnd_b[21:18])),
                         entry: '{ptag: pick_ptag(rnd_c), u: rnd_c[30],
                                  w: rnd_c[31] | rnd_c[29], d: rnd_c[28] | rnd_c[0]}};
      end else if (rnd_a[15:11] == 5'd0) begin
        sfence_i = 1'b1;
      end
      poison_i = (rnd_a[19:17] == 3'd0);
      if (rnd_a[24:20] == 5'd0) begin
        translation_en_i = rnd_b[12] | rnd_b[13];
        case (rnd_b[15:14])
          2'd0:    priv_mode_i = e_priv_user;
          2'd1:    priv_mode_i = e_priv_supervisor;
          default: priv_mode_i = e_priv_machine;
        endcase
        mstatus_sum_i   = rnd_b[16];
        uncached_mode_i = rnd_b[17];
      end
    end
    wait_drain();

    if ((resp_count == live_count) && (exp_q.size() == 0)) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("** Error at %0t ns: %0d responses for %0d live commands",
               $time, resp_count, live_count);
      abort_run();
    end
  end

endmodule

/* sources.f */
+incdir+rtl
rtl/mmu_pkg.sv
rtl/dtlb.sv
rtl/access_check.sv
rtl/mem_xlate_top.sv
verification/tb_mem_xlate.sv

/* Makefile */
# Verilator build and run of the data translation path testbench.
# Any variable below can be overridden on the command line,
# for example: make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mem_xlate
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

# Rebuild whenever a listed source changes
$(SIM_BIN): $(shell sed -n '/^[^+]/p' $(FILELIST)) rtl/mmu_settings.svh
